// ==== upsample_vectors.txt ====
// Each line holds one hex pixel. The 16 source pixels come first and the 49 expected outputs follow.
10
ff
03
80
41
00
7e
22
c5
9a
01
ee
33
64
f0
0d
10
87
ff
81
03
41
80
28
54
7f
60
40
48
51
41
20
00
3f
7e
50
22
83
68
4d
46
3f
63
88
c5
af
9a
4d
01
77
ee
7c
7d
7f
7b
78
7b
7d
33
4b
64
aa
f0
7e
0d

// ==== tb.f ====
upsample_pkg.sv
pixel_ram.sv
mem_arbiter.sv
tile_fetch.sv
tile_interp.sv
tile_writer.sv
upsample_top.sv
upsample_assertions.sv
tb_upsample.sv

// ==== Makefile ====
TOP = tb_upsample

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== tb_upsample.sv ====
`timescale 1ns/100ps

module tb_upsample;

    localparam int pixel_width = 8;
    localparam int img_w = 4;
    localparam int img_h = 4;
    localparam int out_w = 2 * img_w - 1;
    localparam int src_pixels = img_w * img_h;
    localparam int out_pixels = out_w * (2 * img_h - 1);
    localparam int src_aw = $clog2(src_pixels);
    localparam int out_aw = $clog2(out_pixels);
    localparam int busy_timeout = 20;
    localparam int done_timeout = 4000;

    logic                   clk;
    logic                   rst;
    logic                   load_en;
    logic [src_aw-1:0]      load_addr;
    logic [pixel_width-1:0] load_data;
    logic                   start;
    logic                   rd_en;
    logic [out_aw-1:0]      rd_addr;
    logic [pixel_width-1:0] rd_data;
    logic                   rd_valid;
    logic                   busy;
    logic                   done;

    logic [pixel_width-1:0] vec [src_pixels + out_pixels]; // source pixels, then expected output.
    logic [31:0]            lfsr_state;
    logic                   prev_rd_en;

    upsample_top #(
        .pixel_width(pixel_width),
        .img_w      (img_w),
        .img_h      (img_h)
    ) i_upsample_top (
        .clk      (clk),
        .rst      (rst),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .start    (start),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %0h got %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // an output pixel is the truncated mean of the source pixels around it.
    function automatic logic [pixel_width-1:0] rule_pixel(input int r, input int c);
        int x0;
        int y0;
        int x1;
        int y1;
        int sum;
        x0 = c / 2;
        y0 = r / 2;
        x1 = x0 + c % 2;
        y1 = y0 + r % 2;
        sum = int'(vec[y0 * img_w + x0]) + int'(vec[y0 * img_w + x1])
            + int'(vec[y1 * img_w + x0]) + int'(vec[y1 * img_w + x1]);
        return pixel_width'(sum / 4);
    endfunction

    task automatic check_vectors();
        int idx;
        for (int r = 0; r < 2 * img_h - 1; r++) begin
            for (int c = 0; c < out_w; c++) begin
                idx = src_pixels + r * out_w + c;
                compare($sformatf("vector %0d", idx), 32'(rule_pixel(r, c)), 32'(vec[idx]));
            end
        end
    endtask

    task automatic load_image();
        for (int i = 0; i < src_pixels; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= src_aw'(i);
            load_data <= vec[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_busy();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy !== 1'b1) begin
            if (cycles >= busy_timeout) begin
                report_timeout("busy");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_done(input logic host_traffic);
        int          cycles;
        logic [31:0] bits;
        logic        seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            if (host_traffic) begin
                random_bits(1, bits);
                rd_en <= bits[0];
                random_bits(out_aw, bits);
                rd_addr <= out_aw'(bits % out_pixels);
            end
            @(negedge clk);
            seen = (done === 1'b1);
            cycles++;
            if (!seen && cycles >= done_timeout) begin
                report_timeout("done");
            end
        end
        @(posedge clk);
        rd_en <= 1'b0;
    endtask

    task automatic read_pixel(input logic [out_aw-1:0] addr,
                              output logic [pixel_width-1:0] value);
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= addr;
        @(posedge clk);
        rd_en <= 1'b0;
        @(negedge clk);
        compare("rd_valid", 32'd1, 32'(rd_valid));
        value = rd_data;
    endtask

    task automatic check_image();
        logic [pixel_width-1:0] value;
        for (int i = 0; i < out_pixels; i++) begin
            read_pixel(out_aw'(i), value);
            compare($sformatf("rd_data[%0d]", i), 32'(vec[src_pixels + i]), 32'(value));
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            prev_rd_en = 1'b0;
        end else begin
            compare("rd_valid", 32'(prev_rd_en), 32'(rd_valid));
            if (done === 1'b1) begin
                compare("busy", 32'd0, 32'(busy));
            end
            prev_rd_en = rd_en;
        end
    end

    initial begin
        rst        = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        lfsr_state = 32'he01df791;
        $readmemh("upsample_vectors.txt", vec);
        check_vectors();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare("busy", 32'd0, 32'(busy));
        compare("done", 32'd0, 32'(done));
        compare("rd_valid", 32'd0, 32'(rd_valid));

        load_image();
        pulse_start();
        wait_busy();
        wait_done(1'b1); // host reads steal output RAM cycles from the writer.
        check_image();

        pulse_start();
        wait_busy();
        load_image(); // rewriting the same source pixels stalls the tile reads.
        wait_done(1'b0);
        check_image();

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== upsample_assertions.sv ====
`timescale 1ns/100ps

module upsample_assertions #(
    parameter int src_aw = 4,
    parameter int dst_aw = 6
) (
    input logic              clk,
    input logic              rst,
    input logic              load_en,
    input logic              rd_en,
    input logic              rd_valid,
    input logic              src_req,
    input logic [src_aw-1:0] src_addr,
    input logic              src_gnt,
    input logic              dst_req,
    input logic [dst_aw-1:0] dst_addr,
    input logic              dst_gnt,
    input logic              busy,
    input logic              done
);

    rd_valid_after_rd_en: assert property (
        @(posedge clk) disable iff (rst) rd_en |=> rd_valid
    ) else $error("rd_valid did not follow rd_en after one cycle");

    rd_valid_only_after_rd_en: assert property (
        @(posedge clk) disable iff (rst) rd_valid |-> $past(rd_en)
    ) else $error("rd_valid rose without a read one cycle before");

    // a request the host displaces gets no grant and waits with its address held.
    src_wait_under_load: assert property (
        @(posedge clk) disable iff (rst)
        src_req && load_en |=> !$past(src_gnt) && src_req && $stable(src_addr)
    ) else $error("source engine request was granted or moved during a host load");

    dst_wait_under_read: assert property (
        @(posedge clk) disable iff (rst)
        dst_req && rd_en |=> !$past(dst_gnt) && dst_req && $stable(dst_addr)
    ) else $error("output engine request was granted or moved during a host read");

    done_not_with_busy: assert property (
        @(posedge clk) disable iff (rst) done |-> !busy
    ) else $error("done was high while busy was high");

endmodule

bind upsample_top upsample_assertions #(
    .src_aw(src_aw),
    .dst_aw(dst_aw)
) i_upsample_assertions (
    .clk     (clk),
    .rst     (rst),
    .load_en (load_en),
    .rd_en   (rd_en),
    .rd_valid(rd_valid),
    .src_req (src_req),
    .src_addr(src_addr),
    .src_gnt (src_gnt),
    .dst_req (dst_req),
    .dst_addr(dst_addr),
    .dst_gnt (dst_gnt),
    .busy    (busy),
    .done    (done)
);

// ==== upsample_top.sv ====
`timescale 1ns/100ps

module upsample_top import upsample_pkg::*; #(
    parameter int pixel_width = 8,
    parameter int img_w = 4,
    parameter int img_h = 4,
    localparam int src_aw = $clog2(img_w * img_h),
    localparam int dst_aw = $clog2((2 * img_w - 1) * (2 * img_h - 1)),
    localparam int tx_w = $clog2(img_w),
    localparam int ty_w = $clog2(img_h)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_en,
    input  logic [src_aw-1:0]      load_addr,
    input  logic [pixel_width-1:0] load_data,
    input  logic                   start,
    input  logic                   rd_en,
    input  logic [dst_aw-1:0]      rd_addr,
    output logic [pixel_width-1:0] rd_data,
    output logic                   rd_valid,
    output logic                   busy,
    output logic                   done
);

    logic [src_aw-1:0]      src_ram_addr;
    logic [pixel_width-1:0] src_ram_wdata;
    logic                   src_ram_we;
    logic [pixel_width-1:0] src_rdata;
    logic                   src_req;
    logic [src_aw-1:0]      src_addr;
    logic                   src_gnt;
    logic                   src_rvalid;

    logic [dst_aw-1:0]      dst_ram_addr;
    logic [pixel_width-1:0] dst_ram_wdata;
    logic                   dst_ram_we;
    logic                   dst_req;
    logic [dst_aw-1:0]      dst_addr;
    logic [pixel_width-1:0] dst_wdata;
    logic                   dst_gnt;

    logic                   busy_fetch;
    logic                   busy_write;
    logic                   all_fetched;
    logic                   writer_free;
    logic                   tile_valid;
    logic [pixel_width-1:0] a, b, c, d;
    logic [tx_w-1:0]        tile_x;
    logic [ty_w-1:0]        tile_y;
    edge_mode_t             edge_mode;

    assign busy = busy_fetch | busy_write;

    pixel_ram #(.width(pixel_width), .depth(img_w * img_h)) i_src_ram (
        .clk(clk), .addr(src_ram_addr), .wdata(src_ram_wdata), .we(src_ram_we), .rdata(src_rdata)
    );

    pixel_ram #(.width(pixel_width), .depth((2 * img_w - 1) * (2 * img_h - 1))) i_dst_ram (
        .clk(clk), .addr(dst_ram_addr), .wdata(dst_ram_wdata), .we(dst_ram_we), .rdata(rd_data)
    );

    // the host only writes the source image, the engine only reads it.
    mem_arbiter #(.addr_width(src_aw), .width(pixel_width)) i_src_arb (
        .clk(clk), .rst(rst),
        .host_en(load_en), .host_addr(load_addr), .host_wdata(load_data), .host_we(1'b1),
        .host_rvalid(),
        .eng_req(src_req), .eng_addr(src_addr), .eng_wdata('0), .eng_we(1'b0),
        .eng_gnt(src_gnt), .eng_rvalid(src_rvalid),
        .ram_addr(src_ram_addr), .ram_wdata(src_ram_wdata), .ram_we(src_ram_we)
    );

    // the host only reads the output image, the engine only writes it.
    mem_arbiter #(.addr_width(dst_aw), .width(pixel_width)) i_dst_arb (
        .clk(clk), .rst(rst),
        .host_en(rd_en), .host_addr(rd_addr), .host_wdata('0), .host_we(1'b0),
        .host_rvalid(rd_valid),
        .eng_req(dst_req), .eng_addr(dst_addr), .eng_wdata(dst_wdata), .eng_we(1'b1),
        .eng_gnt(dst_gnt), .eng_rvalid(),
        .ram_addr(dst_ram_addr), .ram_wdata(dst_ram_wdata), .ram_we(dst_ram_we)
    );

    tile_fetch #(.pixel_width(pixel_width), .img_w(img_w), .img_h(img_h)) i_tile_fetch (
        .clk(clk), .rst(rst), .start(start), .writer_free(writer_free),
        .busy_fetch(busy_fetch), .all_fetched(all_fetched),
        .src_req(src_req), .src_addr(src_addr), .src_gnt(src_gnt),
        .src_rvalid(src_rvalid), .src_rdata(src_rdata),
        .tile_valid(tile_valid), .a(a), .b(b), .c(c), .d(d),
        .tile_x(tile_x), .tile_y(tile_y), .edge_mode(edge_mode)
    );

    tile_writer #(.pixel_width(pixel_width), .img_w(img_w), .img_h(img_h)) i_tile_writer (
        .clk(clk), .rst(rst), .tile_valid(tile_valid), .a(a), .b(b), .c(c), .d(d),
        .tile_x(tile_x), .tile_y(tile_y), .edge_mode(edge_mode), .all_fetched(all_fetched),
        .writer_free(writer_free), .done(done), .busy_write(busy_write),
        .dst_req(dst_req), .dst_addr(dst_addr), .dst_wdata(dst_wdata), .dst_gnt(dst_gnt)
    );

endmodule

// ==== tile_writer.sv ====
`timescale 1ns/100ps

module tile_writer import upsample_pkg::*; #(
    parameter int pixel_width = 8,
    parameter int img_w = 4,
    parameter int img_h = 4,
    localparam int dst_aw = $clog2((2 * img_w - 1) * (2 * img_h - 1)),
    localparam int tx_w = $clog2(img_w),
    localparam int ty_w = $clog2(img_h)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tile_valid,
    input  logic [pixel_width-1:0] a,
    input  logic [pixel_width-1:0] b,
    input  logic [pixel_width-1:0] c,
    input  logic [pixel_width-1:0] d,
    input  logic [tx_w-1:0]        tile_x,
    input  logic [ty_w-1:0]        tile_y,
    input  edge_mode_t             edge_mode,
    input  logic                   all_fetched,
    output logic                   writer_free,
    output logic                   done,
    output logic                   busy_write,
    output logic                   dst_req,
    output logic [dst_aw-1:0]      dst_addr,
    output logic [pixel_width-1:0] dst_wdata,
    input  logic                   dst_gnt
);

    localparam int out_w = 2 * img_w - 1;

    logic [pixel_width-1:0] ra, rb, rc, rd;
    logic [pixel_width-1:0] p00, p01, p02, p10, p11, p12, p20, p21, p22;
    logic [tx_w-1:0]        rtx;
    logic [ty_w-1:0]        rty;
    logic                   writing;
    logic [1:0]             row;
    logic [1:0]             col;
    logic [1:0]             col_first; // column a patch row restarts at.
    logic [31:0]            dst_pos;
    logic                   last_write;
    logic                   own_row0;
    logic                   own_col0;

    tile_interp #(
        .pixel_width(pixel_width)
    ) i_tile_interp (
        .a  (ra),
        .b  (rb),
        .c  (rc),
        .d  (rd),
        .p00(p00),
        .p01(p01),
        .p02(p02),
        .p10(p10),
        .p11(p11),
        .p12(p12),
        .p20(p20),
        .p21(p21),
        .p22(p22)
    );

    assign own_row0 = (edge_mode == mode_first_row) || (edge_mode == mode_corner);
    assign own_col0 = (edge_mode == mode_first_col) || (edge_mode == mode_corner);

    assign writer_free = ~writing;
    assign busy_write  = writing;
    assign dst_req     = writing;
    assign last_write  = writing && dst_gnt && (row == 2'd2) && (col == 2'd2);

    assign dst_pos  = (2 * 32'(rty) + 32'(row)) * out_w + 2 * 32'(rtx) + 32'(col);
    assign dst_addr = dst_pos[dst_aw-1:0];

    always_comb begin
        case ({row, col})
            4'h0: dst_wdata = p00;
            4'h1: dst_wdata = p01;
            4'h2: dst_wdata = p02;
            4'h4: dst_wdata = p10;
            4'h5: dst_wdata = p11;
            4'h6: dst_wdata = p12;
            4'h8: dst_wdata = p20;
            4'h9: dst_wdata = p21;
            default: dst_wdata = p22;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writing   <= 1'b0;
            row       <= '0;
            col       <= '0;
            col_first <= '0;
            done      <= 1'b0;
        end else begin
            done <= last_write && all_fetched; // only the final tile ends after all_fetched.
            if (!writing && tile_valid) begin
                writing   <= 1'b1;
                row       <= own_row0 ? 2'd0 : 2'd1;
                col       <= own_col0 ? 2'd0 : 2'd1;
                col_first <= own_col0 ? 2'd0 : 2'd1;
            end else if (writing && dst_gnt) begin
                if (col == 2'd2) begin
                    col <= col_first;
                    if (row == 2'd2) begin
                        writing <= 1'b0;
                    end else begin
                        row <= row + 2'd1;
                    end
                end else begin
                    col <= col + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!writing && tile_valid) begin
            ra  <= a;
            rb  <= b;
            rc  <= c;
            rd  <= d;
            rtx <= tile_x;
            rty <= tile_y;
        end
    end

endmodule

// ==== tile_interp.sv ====
`timescale 1ns/100ps

module tile_interp #(
    parameter int pixel_width = 8
) (
    input  logic [pixel_width-1:0] a,
    input  logic [pixel_width-1:0] b,
    input  logic [pixel_width-1:0] c,
    input  logic [pixel_width-1:0] d,
    output logic [pixel_width-1:0] p00,
    output logic [pixel_width-1:0] p01,
    output logic [pixel_width-1:0] p02,
    output logic [pixel_width-1:0] p10,
    output logic [pixel_width-1:0] p11,
    output logic [pixel_width-1:0] p12,
    output logic [pixel_width-1:0] p20,
    output logic [pixel_width-1:0] p21,
    output logic [pixel_width-1:0] p22
);

    logic [pixel_width:0]   sum_ab;
    logic [pixel_width:0]   sum_ac;
    logic [pixel_width:0]   sum_bd;
    logic [pixel_width:0]   sum_cd;
    logic [pixel_width+1:0] sum_all; // four pixels need two extra bits.

    assign sum_ab  = {1'b0, a} + {1'b0, b};
    assign sum_ac  = {1'b0, a} + {1'b0, c};
    assign sum_bd  = {1'b0, b} + {1'b0, d};
    assign sum_cd  = {1'b0, c} + {1'b0, d};
    assign sum_all = {2'b00, a} + {2'b00, b} + {2'b00, c} + {2'b00, d};

    assign p00 = a;
    assign p02 = b;
    assign p20 = c;
    assign p22 = d;

    // dropping the low bits truncates the average.
    assign p01 = sum_ab[pixel_width:1];
    assign p10 = sum_ac[pixel_width:1];
    assign p12 = sum_bd[pixel_width:1];
    assign p21 = sum_cd[pixel_width:1];
    assign p11 = sum_all[pixel_width+1:2];

endmodule

// ==== tile_fetch.sv ====
`timescale 1ns/100ps

module tile_fetch import upsample_pkg::*; #(
    parameter int pixel_width = 8,
    parameter int img_w = 4,
    parameter int img_h = 4,
    localparam int src_aw = $clog2(img_w * img_h),
    localparam int tx_w = $clog2(img_w),
    localparam int ty_w = $clog2(img_h)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   writer_free,
    output logic                   busy_fetch,
    output logic                   all_fetched,
    output logic                   src_req,
    output logic [src_aw-1:0]      src_addr,
    input  logic                   src_gnt,
    input  logic                   src_rvalid,
    input  logic [pixel_width-1:0] src_rdata,
    output logic                   tile_valid,
    output logic [pixel_width-1:0] a,
    output logic [pixel_width-1:0] b,
    output logic [pixel_width-1:0] c,
    output logic [pixel_width-1:0] d,
    output logic [tx_w-1:0]        tile_x,
    output logic [ty_w-1:0]        tile_y,
    output edge_mode_t             edge_mode
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_read = 2'd1;
    localparam logic [1:0] st_hand = 2'd2;

    logic [1:0]  state;
    logic [2:0]  req_cnt; // reads granted for this tile, 0 to 4.
    logic [1:0]  cap_cnt; // pixels caught for this tile.
    logic [31:0] src_pos;
    logic        last_tile;

    // read k goes to x plus bit 0 of k and y plus bit 1 of k.
    assign src_pos = (32'(tile_y) + 32'(req_cnt[1])) * img_w + 32'(tile_x) + 32'(req_cnt[0]);
    assign src_addr = src_pos[src_aw-1:0];
    assign src_req = (state == st_read) && !req_cnt[2];

    assign tile_valid = (state == st_hand) && writer_free;
    assign edge_mode = edge_mode_t'({tile_x == '0, tile_y == '0});
    assign last_tile = (32'(tile_x) == img_w - 2) && (32'(tile_y) == img_h - 2);
    assign busy_fetch = (state != st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            req_cnt     <= '0;
            cap_cnt     <= '0;
            tile_x      <= '0;
            tile_y      <= '0;
            all_fetched <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start && writer_free) begin // a start while the writer drains is ignored.
                        state       <= st_read;
                        req_cnt     <= '0;
                        cap_cnt     <= '0;
                        tile_x      <= '0;
                        tile_y      <= '0;
                        all_fetched <= 1'b0;
                    end
                end
                st_read: begin
                    if (src_req && src_gnt) begin
                        req_cnt <= req_cnt + 3'd1;
                    end
                    if (src_rvalid) begin
                        cap_cnt <= cap_cnt + 2'd1;
                        if (cap_cnt == 2'd3) begin
                            state <= st_hand;
                        end
                    end
                end
                st_hand: begin
                    if (writer_free) begin
                        req_cnt <= '0;
                        cap_cnt <= '0;
                        if (last_tile) begin
                            state       <= st_idle;
                            all_fetched <= 1'b1;
                        end else begin
                            state <= st_read;
                            if (32'(tile_x) == img_w - 2) begin
                                tile_x <= '0;
                                tile_y <= tile_y + 1'b1;
                            end else begin
                                tile_x <= tile_x + 1'b1;
                            end
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_read && src_rvalid) begin
            case (cap_cnt)
                2'd0: a <= src_rdata;
                2'd1: b <= src_rdata;
                2'd2: c <= src_rdata;
                default: d <= src_rdata;
            endcase
        end
    end

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter import upsample_pkg::*; #(
    parameter int addr_width = 4,
    parameter int width = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  host_en,
    input  logic [addr_width-1:0] host_addr,
    input  logic [width-1:0]      host_wdata,
    input  logic                  host_we,
    output logic                  host_rvalid,
    input  logic                  eng_req,
    input  logic [addr_width-1:0] eng_addr,
    input  logic [width-1:0]      eng_wdata,
    input  logic                  eng_we,
    output logic                  eng_gnt,
    output logic                  eng_rvalid,
    output logic [addr_width-1:0] ram_addr,
    output logic [width-1:0]      ram_wdata,
    output logic                  ram_we
);

    req_sel_t rd_sel;
    logic     rd_pending;
    logic     read_issue;

    assign eng_gnt    = eng_req & ~host_en; // the host strobe has no handshake, so it always wins.
    assign ram_addr   = host_en ? host_addr : eng_addr;
    assign ram_wdata  = host_en ? host_wdata : eng_wdata;
    assign ram_we     = host_en ? host_we : (eng_gnt & eng_we);
    assign read_issue = host_en ? ~host_we : (eng_gnt & ~eng_we);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending <= 1'b0;
            rd_sel     <= req_host;
        end else begin
            rd_pending <= read_issue;
            rd_sel     <= host_en ? req_host : req_engine;
        end
    end

    assign host_rvalid = rd_pending && (rd_sel == req_host);
    assign eng_rvalid  = rd_pending && (rd_sel == req_engine);

endmodule

// ==== pixel_ram.sv ====
`timescale 1ns/100ps

module pixel_ram #(
    parameter int width = 8,
    parameter int depth = 16,
    localparam int addr_width = $clog2(depth)
) (
    input  logic                  clk,
    input  logic [addr_width-1:0] addr,
    input  logic [width-1:0]      wdata,
    input  logic                  we,
    output logic [width-1:0]      rdata
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // read data comes one cycle after the address.
    end

endmodule

// ==== upsample_pkg.sv ====
package upsample_pkg;

    // which patch border a tile owns.
    // row 0 is written only by tiles with y of 0, column 0 only by tiles with x of 0.
    typedef enum logic [1:0] {
        mode_interior  = 2'b00, // y > 0 and x > 0.
        mode_first_row = 2'b01, // y = 0 only.
        mode_first_col = 2'b10, // x = 0 only.
        mode_corner    = 2'b11  // both x and y are 0.
    } edge_mode_t;

    // owner of the RAM read issued in the previous cycle.
    typedef enum logic {
        req_host   = 1'b0,
        req_engine = 1'b1
    } req_sel_t;

endpackage
